// File: compile.f
verilog/csr_pkg.sv
verilog/csr_control.sv
verilog/csr_file.sv
verilog/csr_access_unit.sv
verilog/csr_irq_unit.sv
verilog/csr_subsystem.sv
tb/csr_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the CSR testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/100ps -f compile.f --top-module csr_subsystem_tb \
    -o csr_sim > sim.log 2>&1 \
    && ./obj_dir/csr_sim >> sim.log 2>&1
grep -q "^TESTS PASSED$" sim.log \
    && echo "simulation passed, see sim.log" \
    && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: tb/csr_subsystem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module csr_subsystem_tb
    import csr_pkg::*;
;

    localparam logic [31:0] TVEC    = 32'h0000_0104;
    localparam int          TIMEOUT = 50;

    // stimulus and expected response for one step
    // irqs bit order is ext soft timer
    typedef struct packed {
        logic        irq_only;
        csr_op_t     op;
        csr_addr_t   addr;
        logic [31:0] wdata;
        logic [31:0] pc;
        cause_code_t exc;
        logic [2:0]  irqs;
        logic [31:0] rdata;
        logic        illegal;
        logic        redirect;
        logic [31:0] rpc;
        cause_code_t cause;
        priv_t       priv;
        logic        skip;
    } step_t;

    logic        clk;
    logic        rst;
    logic        req_valid;
    csr_op_t     req_op;
    csr_addr_t   req_addr;
    logic [31:0] req_wdata;
    logic [31:0] req_pc;
    cause_code_t req_exc_code;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        resp_illegal;
    logic        resp_redirect;
    logic [31:0] resp_redirect_pc;
    cause_code_t resp_cause;
    logic        resp_ready;
    logic        timer_irq;
    logic        soft_irq;
    logic        ext_irq;
    priv_t       priv_mode;

    step_t       steps[$];
    logic [31:0] cycle_reads[$];
    step_t       s;
    logic [70:0] snapshot;
    logic        ok;
    logic        timed_out;
    integer      seed;
    int          hold;
    int          passed;
    int          failed;
    int          step_errors;
    string       kind;

    csr_subsystem #(.XLEN(32), .HART_ID(5)) uut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_pc(req_pc), .req_exc_code(req_exc_code),
        .req_ready(req_ready), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .resp_illegal(resp_illegal), .resp_redirect(resp_redirect),
        .resp_redirect_pc(resp_redirect_pc), .resp_cause(resp_cause),
        .resp_ready(resp_ready), .timer_irq(timer_irq), .soft_irq(soft_irq),
        .ext_irq(ext_irq), .priv_mode(priv_mode)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected mstatus from its three fields
    function automatic logic [31:0] status_word(logic mie_bit, logic mpie_bit, priv_t mpp);
        logic [31:0] w;
        w = 32'h0;
        w[MSTATUS_MIE] = mie_bit;
        w[MSTATUS_MPIE] = mpie_bit;
        w[MSTATUS_MPP_LO +: 2] = mpp;
        return w;
    endfunction

    function automatic void access_entry(csr_op_t op, csr_addr_t addr, logic [31:0] wdata,
                                         logic [2:0] irqs, logic [31:0] rdata, priv_t priv);
        step_t e;
        e = '0;
        e.op = op;
        e.addr = addr;
        e.wdata = wdata;
        e.pc = 32'h0000_1000;
        e.irqs = irqs;
        e.rdata = rdata;
        e.priv = priv;
        steps.push_back(e);
    endfunction

    // every trap lands in machine mode at mtvec
    function automatic void trap_entry(csr_op_t op, csr_addr_t addr, logic [31:0] wdata,
                                       logic [31:0] pc, cause_code_t cause, logic illegal);
        step_t e;
        e = '0;
        e.op = op;
        e.addr = addr;
        e.wdata = wdata;
        e.pc = pc;
        e.exc = cause;
        e.illegal = illegal;
        e.redirect = 1'b1;
        e.rpc = TVEC;
        e.cause = cause;
        e.priv = PRIV_MACHINE;
        steps.push_back(e);
    endfunction

    function automatic void mret_entry(logic [31:0] pc, logic [31:0] rpc, priv_t priv);
        step_t e;
        e = '0;
        e.op = OP_MRET;
        e.pc = pc;
        e.redirect = 1'b1;
        e.rpc = rpc;
        e.priv = priv;
        steps.push_back(e);
    endfunction

    function automatic void irq_entry(logic [2:0] irqs, cause_code_t cause);
        step_t e;
        e = '0;
        e.irq_only = 1'b1;
        e.op = OP_CSRRS;
        e.irqs = irqs;
        e.redirect = 1'b1;
        e.rpc = TVEC;
        e.cause = cause;
        e.priv = PRIV_MACHINE;
        steps.push_back(e);
    endfunction

    function automatic void mcycle_entry();
        step_t e;
        e = '0;
        e.op = OP_CSRRS;
        e.addr = CSR_MCYCLE;
        e.priv = PRIV_MACHINE;
        e.skip = 1'b1;
        steps.push_back(e);
    endfunction

    function automatic void load_steps();
        // reset values and a scratch write with read back
        access_entry(OP_CSRRS, CSR_MHARTID, 32'h0, 3'b000, 32'h5, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSCRATCH, 32'h0, 3'b000, 32'h0, PRIV_MACHINE);
        access_entry(OP_CSRRW, CSR_MSCRATCH, 32'ha5a5_0001, 3'b000, 32'h0, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSCRATCH, 32'h0, 3'b000, 32'ha5a5_0001, PRIV_MACHINE);
        // write masks
        access_entry(OP_CSRRW, CSR_MTVEC, 32'h0000_0107, 3'b000, 32'h0, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MTVEC, 32'h0, 3'b000, TVEC, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MIE, 32'hffff_ffff, 3'b000, 32'h0, PRIV_MACHINE);
        access_entry(OP_CSRRC, CSR_MIE, 32'h8, 3'b000, 32'h888, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MIE, 32'h0, 3'b000, 32'h880, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSTATUS, 32'hffff_ffff, 3'b000, 32'h0, PRIV_MACHINE);
        access_entry(OP_CSRRC, CSR_MSTATUS, 32'h8, 3'b000,
                     status_word(1'b1, 1'b1, PRIV_MACHINE), PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSTATUS, 32'h0, 3'b000,
                     status_word(1'b0, 1'b1, PRIV_MACHINE), PRIV_MACHINE);
        // ecall from machine mode then mret into user mode
        trap_entry(OP_ECALL, 12'h0, 32'h0, 32'h0000_0200, CAUSE_ECALL_M, 1'b0);
        access_entry(OP_CSRRS, CSR_MCAUSE, 32'h0, 3'b000, 32'hb, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MEPC, 32'h0, 3'b000, 32'h200, PRIV_MACHINE);
        access_entry(OP_CSRRC, CSR_MSTATUS, 32'h1800, 3'b000,
                     status_word(1'b0, 1'b0, PRIV_MACHINE), PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSTATUS, 32'h80, 3'b000, 32'h0, PRIV_MACHINE);
        access_entry(OP_CSRRW, CSR_MEPC, 32'h300, 3'b000, 32'h200, PRIV_MACHINE);
        mret_entry(32'h0000_0210, 32'h0000_0300, PRIV_USER);
        // user mode csr write traps and leaves mscratch alone
        trap_entry(OP_CSRRW, CSR_MSCRATCH, 32'h5a5a_0002, 32'h0000_0400, CAUSE_ILLEGAL, 1'b1);
        // MPIE shows that mret brought MIE back
        access_entry(OP_CSRRS, CSR_MSTATUS, 32'h0, 3'b000,
                     status_word(1'b0, 1'b1, PRIV_USER), PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MCAUSE, 32'h0, 3'b000, 32'h2, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MEPC, 32'h0, 3'b000, 32'h400, PRIV_MACHINE);
        mret_entry(32'h0000_0410, 32'h0000_0400, PRIV_USER);
        trap_entry(OP_ECALL, 12'h0, 32'h0, 32'h0000_0500, CAUSE_ECALL_U, 1'b0);
        access_entry(OP_CSRRS, CSR_MCAUSE, 32'h0, 3'b000, 32'h8, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MEPC, 32'h0, 3'b000, 32'h500, PRIV_MACHINE);
        trap_entry(OP_EXCEPTION, 12'h0, 32'h0, 32'h0000_0700, 5'd5, 1'b0);
        access_entry(OP_CSRRS, CSR_MCAUSE, 32'h0, 3'b000, 32'h5, PRIV_MACHINE);
        // machine mode illegal accesses
        trap_entry(OP_CSRRS, 12'h7c0, 32'h0, 32'h0000_0600, CAUSE_ILLEGAL, 1'b1);
        trap_entry(OP_CSRRW, CSR_MHARTID, 32'h9, 32'h0000_0604, CAUSE_ILLEGAL, 1'b1);
        trap_entry(OP_CSRRS, CSR_MIP, 32'h80, 32'h0000_0608, CAUSE_ILLEGAL, 1'b1);
        access_entry(OP_CSRRS, CSR_MHARTID, 32'h0, 3'b000, 32'h5, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSCRATCH, 32'h0, 3'b000, 32'ha5a5_0001, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MEPC, 32'h0, 3'b000, 32'h608, PRIV_MACHINE);
        // timer interrupt alone and then together with external
        access_entry(OP_CSRRS, CSR_MSTATUS, 32'h8, 3'b000,
                     status_word(1'b0, 1'b0, PRIV_MACHINE), PRIV_MACHINE);
        irq_entry(3'b001, IRQ_TIMER);
        access_entry(OP_CSRRS, CSR_MCAUSE, 32'h0, 3'b001, 32'h8000_0007, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MIP, 32'h0, 3'b001, 32'h80, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MEPC, 32'h0, 3'b000, 32'h0, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSTATUS, 32'h8, 3'b000,
                     status_word(1'b0, 1'b1, PRIV_MACHINE), PRIV_MACHINE);
        irq_entry(3'b101, IRQ_EXT);
        access_entry(OP_CSRRS, CSR_MCAUSE, 32'h0, 3'b101, 32'h8000_000b, PRIV_MACHINE);
        // with the enables cleared the request goes through untouched
        access_entry(OP_CSRRC, CSR_MIE, 32'h880, 3'b101, 32'h880, PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSTATUS, 32'h8, 3'b101,
                     status_word(1'b0, 1'b1, PRIV_MACHINE), PRIV_MACHINE);
        access_entry(OP_CSRRS, CSR_MSCRATCH, 32'h0, 3'b101, 32'ha5a5_0001, PRIV_MACHINE);
        mcycle_entry();
        mcycle_entry();
    endfunction

    function automatic logic [70:0] resp_fields();
        return {resp_rdata, resp_illegal, resp_redirect, resp_redirect_pc, resp_cause};
    endfunction

    task automatic wait_req_ready(output logic done);
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        done = req_ready;
    endtask

    task automatic wait_resp_valid(output logic done);
        int n;
        n = 0;
        @(negedge clk);
        while (!resp_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        done = resp_valid;
    endtask

    initial begin
        seed = 32'hd9e634e3;
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = OP_CSRRS;
        req_addr = 12'h0;
        req_wdata = 32'h0;
        req_pc = 32'h0;
        req_exc_code = 5'd0;
        resp_ready = 1'b0;
        timer_irq = 1'b0;
        soft_irq = 1'b0;
        ext_irq = 1'b0;
        passed = 0;
        failed = 0;
        timed_out = 1'b0;
        load_steps();
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            s = steps[i];
            step_errors = 0;
            if (s.irq_only) kind = "irq";
            else kind = s.op.name();
            @(posedge clk);
            ext_irq <= s.irqs[2];
            soft_irq <= s.irqs[1];
            timer_irq <= s.irqs[0];
            ok = 1'b1;
            if (!s.irq_only) begin
                req_valid <= 1'b1;
                req_op <= s.op;
                req_addr <= s.addr;
                req_wdata <= s.wdata;
                req_pc <= s.pc;
                req_exc_code <= s.exc;
                wait_req_ready(ok);
                // request transfers on this edge
                if (ok) begin
                    @(posedge clk);
                    req_valid <= 1'b0;
                end
            end
            if (ok) wait_resp_valid(ok);
            if (!ok) begin
                timed_out = 1'b1;
                failed++;
                $display("step %0d %s timed out waiting for the DUT handshake", i, kind);
            end else begin
                if (!s.skip && resp_rdata !== s.rdata) begin
                    $display("FAIL step %0d resp_rdata got %h expected %h",
                             i, resp_rdata, s.rdata);
                    step_errors++;
                end
                if (resp_illegal !== s.illegal) begin
                    $display("FAIL step %0d resp_illegal got %h expected %h",
                             i, resp_illegal, s.illegal);
                    step_errors++;
                end
                if (resp_redirect !== s.redirect) begin
                    $display("FAIL step %0d resp_redirect got %h expected %h",
                             i, resp_redirect, s.redirect);
                    step_errors++;
                end
                if (s.redirect && resp_redirect_pc !== s.rpc) begin
                    $display("FAIL step %0d resp_redirect_pc got %h expected %h",
                             i, resp_redirect_pc, s.rpc);
                    step_errors++;
                end
                if (resp_cause !== s.cause) begin
                    $display("FAIL step %0d resp_cause got %h expected %h",
                             i, resp_cause, s.cause);
                    step_errors++;
                end
                if (priv_mode !== s.priv) begin
                    $display("FAIL step %0d priv_mode got %h expected %h",
                             i, priv_mode, s.priv);
                    step_errors++;
                end
                if (s.skip) cycle_reads.push_back(resp_rdata);
                // response must hold still under back-pressure
                snapshot = resp_fields();
                hold = {$random(seed)} % 4;
                for (int h = 0; h < hold; h++) begin
                    @(negedge clk);
                    if (!resp_valid) begin
                        $display("step %0d response dropped while resp_ready was low", i);
                        step_errors++;
                    end
                    if (resp_fields() !== snapshot) begin
                        $display("FAIL step %0d resp fields got %h expected %h",
                                 i, resp_fields(), snapshot);
                        step_errors++;
                    end
                end
                @(posedge clk);
                resp_ready <= 1'b1;
                @(posedge clk);
                resp_ready <= 1'b0;
                if (step_errors == 0) passed++;
                else failed++;
                $display("step %0d %s %s", i, kind, (step_errors == 0) ? "ok" : "failed");
            end
        end

        if (!timed_out) begin
            if (cycle_reads.size() == 2 && cycle_reads[1] > cycle_reads[0]) begin
                passed++;
                $display("mcycle order ok");
            end else begin
                failed++;
                $display("mcycle did not increase between the two reads");
            end
        end
        $display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/csr_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module csr_subsystem
    import csr_pkg::*;
#(
    parameter int XLEN    = 32,
    parameter int HART_ID = 0
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              req_valid,
    input  csr_op_t                req_op,
    input  csr_addr_t              req_addr,
    input  wire logic [XLEN-1:0]   req_wdata,
    input  wire logic [XLEN-1:0]   req_pc,
    input  cause_code_t            req_exc_code,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic [XLEN-1:0]        resp_rdata,
    output logic                   resp_illegal,
    output logic                   resp_redirect,
    output logic [XLEN-1:0]        resp_redirect_pc,
    output cause_code_t            resp_cause,
    input  wire logic              resp_ready,
    input  wire logic              timer_irq,
    input  wire logic              soft_irq,
    input  wire logic              ext_irq,
    output priv_t                  priv_mode
);

    logic [XLEN-1:0] mstatus, mie, mip, mtvec, mscratch;
    logic [XLEN-1:0] mepc, mcause, mtval, mcycle, mhartid;
    logic [XLEN-1:0] old_value;
    logic [XLEN-1:0] new_value;
    logic            write_needed;
    logic            access_illegal;
    logic            irq_take;
    cause_code_t     irq_code;
    logic            resp_load;
    logic            do_write, do_trap, do_mret;
    cause_code_t     trap_cause;
    logic            trap_is_irq;
    logic [XLEN-1:0] trap_pc;
    priv_t           trap_priv;

    csr_control #(.XLEN(XLEN)) u_control (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_op(req_op), .req_pc(req_pc),
        .req_exc_code(req_exc_code), .resp_ready(resp_ready),
        .access_illegal(access_illegal), .write_needed(write_needed),
        .irq_take(irq_take), .irq_code(irq_code),
        .mtvec(mtvec), .mepc(mepc), .mpp(mstatus[MSTATUS_MPP_LO +: 2]),
        .req_ready(req_ready), .resp_valid(resp_valid),
        .resp_illegal(resp_illegal), .resp_redirect(resp_redirect),
        .resp_redirect_pc(resp_redirect_pc), .resp_cause(resp_cause),
        .resp_load(resp_load), .priv_mode(priv_mode),
        .do_write(do_write), .do_trap(do_trap), .do_mret(do_mret),
        .trap_cause(trap_cause), .trap_is_irq(trap_is_irq),
        .trap_pc(trap_pc), .trap_priv(trap_priv)
    );

    csr_file #(.XLEN(XLEN), .HART_ID(HART_ID)) u_file (
        .clk(clk), .rst(rst),
        .do_write(do_write), .write_addr(req_addr), .write_value(new_value),
        .do_trap(do_trap), .trap_cause(trap_cause), .trap_is_irq(trap_is_irq),
        .trap_pc(trap_pc), .trap_priv(trap_priv), .do_mret(do_mret),
        .timer_irq(timer_irq), .soft_irq(soft_irq), .ext_irq(ext_irq),
        .mstatus(mstatus), .mie(mie), .mip(mip), .mtvec(mtvec),
        .mscratch(mscratch), .mepc(mepc), .mcause(mcause), .mtval(mtval),
        .mcycle(mcycle), .mhartid(mhartid)
    );

    csr_access_unit #(.XLEN(XLEN)) u_access (
        .req_op(req_op), .req_addr(req_addr), .req_wdata(req_wdata),
        .priv_mode(priv_mode),
        .mstatus(mstatus), .mie(mie), .mip(mip), .mtvec(mtvec),
        .mscratch(mscratch), .mepc(mepc), .mcause(mcause), .mtval(mtval),
        .mcycle(mcycle), .mhartid(mhartid),
        .old_value(old_value), .new_value(new_value),
        .write_needed(write_needed), .access_illegal(access_illegal)
    );

    csr_irq_unit #(.XLEN(XLEN)) u_irq (
        .mip(mip), .mie(mie), .mstatus_mie(mstatus[MSTATUS_MIE]),
        .priv_mode(priv_mode),
        .irq_take(irq_take), .irq_code(irq_code)
    );

    // read data register, an interrupt response carries no data
    always_ff @(posedge clk) begin
        if (resp_load) begin
            resp_rdata <= irq_take ? '0 : old_value;
        end
    end

endmodule

`default_nettype wire

// File: verilog/csr_irq_unit.sv
`timescale 1ns/100ps
`default_nettype none

module csr_irq_unit
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire logic [XLEN-1:0]   mip,
    input  wire logic [XLEN-1:0]   mie,
    input  wire logic              mstatus_mie,
    input  priv_t                  priv_mode,
    output logic                   irq_take,
    output cause_code_t            irq_code
);

    logic [XLEN-1:0] pending;
    logic            global_en;

    // user mode always sees machine interrupts
    assign global_en = mstatus_mie || (priv_mode == PRIV_USER);
    assign pending   = mip & mie;

    // fixed priority: external, software, timer
    always_comb begin
        irq_take = global_en;
        irq_code = '0;
        if (pending[IRQ_EXT]) begin
            irq_code = IRQ_EXT;
        end else if (pending[IRQ_SOFT]) begin
            irq_code = IRQ_SOFT;
        end else if (pending[IRQ_TIMER]) begin
            irq_code = IRQ_TIMER;
        end else begin
            irq_take = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/csr_access_unit.sv
`timescale 1ns/100ps
`default_nettype none

module csr_access_unit
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  csr_op_t                req_op,
    input  csr_addr_t              req_addr,
    input  wire logic [XLEN-1:0]   req_wdata,
    input  priv_t                  priv_mode,
    input  wire logic [XLEN-1:0]   mstatus,
    input  wire logic [XLEN-1:0]   mie,
    input  wire logic [XLEN-1:0]   mip,
    input  wire logic [XLEN-1:0]   mtvec,
    input  wire logic [XLEN-1:0]   mscratch,
    input  wire logic [XLEN-1:0]   mepc,
    input  wire logic [XLEN-1:0]   mcause,
    input  wire logic [XLEN-1:0]   mtval,
    input  wire logic [XLEN-1:0]   mcycle,
    input  wire logic [XLEN-1:0]   mhartid,
    output logic [XLEN-1:0]        old_value,
    output logic [XLEN-1:0]        new_value,
    output logic                   write_needed,
    output logic                   access_illegal
);

    logic [XLEN-1:0] read_value;
    logic            known;
    logic            read_only;
    logic            is_csr_op;
    logic            writes;

    // address decode
    always_comb begin
        read_value = '0;
        known      = 1'b1;
        read_only  = 1'b0;
        case (req_addr)
            CSR_MSTATUS:  read_value = mstatus;
            CSR_MIE:      read_value = mie;
            CSR_MTVEC:    read_value = mtvec;
            CSR_MSCRATCH: read_value = mscratch;
            CSR_MEPC:     read_value = mepc;
            CSR_MCAUSE:   read_value = mcause;
            CSR_MTVAL:    read_value = mtval;
            CSR_MCYCLE:   read_value = mcycle;
            CSR_MIP: begin
                read_value = mip;
                read_only  = 1'b1;
            end
            CSR_MHARTID: begin
                read_value = mhartid;
                read_only  = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    assign is_csr_op = (req_op == OP_CSRRW) || (req_op == OP_CSRRS) || (req_op == OP_CSRRC);

    // set/clear with zero wdata counts as a pure read
    assign writes = (req_op == OP_CSRRW) || (req_wdata != '0);

    assign access_illegal = is_csr_op
                          && (!known || (read_only && writes) || (priv_mode == PRIV_USER));
    assign write_needed = is_csr_op && writes && !access_illegal;
    assign old_value    = (is_csr_op && !access_illegal) ? read_value : '0;

    always_comb begin
        case (req_op)
            OP_CSRRS: new_value = read_value | req_wdata;
            OP_CSRRC: new_value = read_value & ~req_wdata;
            default:  new_value = req_wdata;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file
    import csr_pkg::*;
#(
    parameter int XLEN    = 32,
    parameter int HART_ID = 0
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              do_write,
    input  csr_addr_t              write_addr,
    input  wire logic [XLEN-1:0]   write_value,
    input  wire logic              do_trap,
    input  cause_code_t            trap_cause,
    input  wire logic              trap_is_irq,
    input  wire logic [XLEN-1:0]   trap_pc,
    input  priv_t                  trap_priv,
    input  wire logic              do_mret,
    input  wire logic              timer_irq,
    input  wire logic              soft_irq,
    input  wire logic              ext_irq,
    output logic [XLEN-1:0]        mstatus,
    output logic [XLEN-1:0]        mie,
    output logic [XLEN-1:0]        mip,
    output logic [XLEN-1:0]        mtvec,
    output logic [XLEN-1:0]        mscratch,
    output logic [XLEN-1:0]        mepc,
    output logic [XLEN-1:0]        mcause,
    output logic [XLEN-1:0]        mtval,
    output logic [XLEN-1:0]        mcycle,
    output logic [XLEN-1:0]        mhartid
);

    // only the three machine interrupt bits exist
    localparam logic [XLEN-1:0] IRQ_MASK = (XLEN'(1) << IRQ_SOFT)
                                         | (XLEN'(1) << IRQ_TIMER)
                                         | (XLEN'(1) << IRQ_EXT);

    logic  st_mie;
    logic  st_mpie;
    priv_t st_mpp;

    // mstatus assembled from its three live fields
    always_comb begin
        mstatus = '0;
        mstatus[MSTATUS_MIE] = st_mie;
        mstatus[MSTATUS_MPIE] = st_mpie;
        mstatus[MSTATUS_MPP_LO +: 2] = st_mpp;
    end

    // mip mirrors the irq lines directly
    always_comb begin
        mip = '0;
        mip[IRQ_SOFT] = soft_irq;
        mip[IRQ_TIMER] = timer_irq;
        mip[IRQ_EXT] = ext_irq;
    end

    assign mhartid = XLEN'(HART_ID);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st_mie   <= 1'b0;
            st_mpie  <= 1'b0;
            st_mpp   <= PRIV_USER;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (do_trap) begin
            st_mpie <= st_mie;
            st_mie  <= 1'b0;
            st_mpp  <= trap_priv;
            mepc    <= trap_pc;
            mcause  <= {trap_is_irq, {(XLEN-6){1'b0}}, trap_cause};
        end else if (do_mret) begin
            st_mie  <= st_mpie;
            st_mpie <= 1'b1;
            st_mpp  <= PRIV_USER;
        end else if (do_write) begin
            case (write_addr)
                CSR_MSTATUS: begin
                    st_mie  <= write_value[MSTATUS_MIE];
                    st_mpie <= write_value[MSTATUS_MPIE];
                    // supervisor encodings fold to machine
                    if (write_value[MSTATUS_MPP_LO +: 2] == PRIV_USER) begin
                        st_mpp <= PRIV_USER;
                    end else begin
                        st_mpp <= PRIV_MACHINE;
                    end
                end
                CSR_MIE:      mie      <= write_value & IRQ_MASK;
                CSR_MTVEC:    mtvec    <= {write_value[XLEN-1:2], 2'b00};
                CSR_MSCRATCH: mscratch <= write_value;
                CSR_MEPC:     mepc     <= write_value;
                CSR_MCAUSE:   mcause   <= write_value;
                CSR_MTVAL:    mtval    <= write_value;
                default: begin
                end
            endcase
        end
    end

    // free running, a direct write replaces the increment
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcycle <= '0;
        end else if (do_write && (write_addr == CSR_MCYCLE)) begin
            mcycle <= write_value;
        end else begin
            mcycle <= mcycle + XLEN'(1);
        end
    end

endmodule

`default_nettype wire

// File: verilog/csr_control.sv
`timescale 1ns/100ps
`default_nettype none

module csr_control
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              req_valid,
    input  csr_op_t                req_op,
    input  wire logic [XLEN-1:0]   req_pc,
    input  cause_code_t            req_exc_code,
    input  wire logic              resp_ready,
    input  wire logic              access_illegal,
    input  wire logic              write_needed,
    input  wire logic              irq_take,
    input  cause_code_t            irq_code,
    input  wire logic [XLEN-1:0]   mtvec,
    input  wire logic [XLEN-1:0]   mepc,
    input  priv_t                  mpp,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic                   resp_illegal,
    output logic                   resp_redirect,
    output logic [XLEN-1:0]        resp_redirect_pc,
    output cause_code_t            resp_cause,
    output logic                   resp_load,
    output priv_t                  priv_mode,
    output logic                   do_write,
    output logic                   do_trap,
    output logic                   do_mret,
    output cause_code_t            trap_cause,
    output logic                   trap_is_irq,
    output logic [XLEN-1:0]        trap_pc,
    output priv_t                  trap_priv
);

    ctrl_state_t state;
    logic        irq_commit;
    logic        req_commit;
    logic        nxt_illegal;

    // interrupts win over any waiting request
    assign req_ready  = (state == ST_IDLE) && !irq_take;
    assign resp_valid = (state == ST_RESP);
    assign irq_commit = (state == ST_IDLE) && irq_take;
    assign req_commit = req_valid && req_ready;
    assign resp_load  = irq_commit || req_commit;
    assign trap_priv  = priv_mode;

    // commit decision
    always_comb begin
        do_write    = 1'b0;
        do_trap     = 1'b0;
        do_mret     = 1'b0;
        trap_cause  = req_exc_code;
        trap_is_irq = 1'b0;
        trap_pc     = req_pc;
        nxt_illegal = 1'b0;
        if (irq_commit) begin
            do_trap     = 1'b1;
            trap_cause  = irq_code;
            trap_is_irq = 1'b1;
            // no instruction behind an interrupt
            trap_pc     = '0;
        end else if (req_commit) begin
            case (req_op)
                OP_ECALL: begin
                    do_trap    = 1'b1;
                    trap_cause = (priv_mode == PRIV_USER) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
                end
                OP_EXCEPTION: begin
                    do_trap = 1'b1;
                end
                OP_MRET: begin
                    if (priv_mode == PRIV_USER) begin
                        do_trap     = 1'b1;
                        trap_cause  = CAUSE_ILLEGAL;
                        nxt_illegal = 1'b1;
                    end else begin
                        do_mret = 1'b1;
                    end
                end
                default: begin
                    if (access_illegal) begin
                        do_trap     = 1'b1;
                        trap_cause  = CAUSE_ILLEGAL;
                        nxt_illegal = 1'b1;
                    end else begin
                        do_write = write_needed;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (resp_load) state <= ST_RESP;
                ST_RESP: if (resp_ready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // privilege follows trap entry and mret
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            priv_mode <= PRIV_MACHINE;
        end else if (do_trap) begin
            priv_mode <= PRIV_MACHINE;
        end else if (do_mret) begin
            priv_mode <= mpp;
        end
    end

    // response fields, held until the handshake
    always_ff @(posedge clk) begin
        if (resp_load) begin
            resp_illegal     <= nxt_illegal;
            resp_redirect    <= do_trap || do_mret;
            resp_redirect_pc <= do_mret ? mepc : mtvec;
            resp_cause       <= do_trap ? trap_cause : '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // address and field types
    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0]  priv_t;
    typedef logic [4:0]  cause_code_t;

    // privilege levels, no supervisor mode here
    localparam priv_t PRIV_USER    = 2'd0;
    localparam priv_t PRIV_MACHINE = 2'd3;

    // synchronous exception codes
    localparam cause_code_t CAUSE_ILLEGAL = 5'd2;
    localparam cause_code_t CAUSE_ECALL_U = 5'd8;
    localparam cause_code_t CAUSE_ECALL_M = 5'd11;

    // interrupt codes, also the bit positions in mip and mie
    localparam cause_code_t IRQ_SOFT  = 5'd3;
    localparam cause_code_t IRQ_TIMER = 5'd7;
    localparam cause_code_t IRQ_EXT   = 5'd11;

    // request kinds on the core port
    typedef enum logic [2:0] {
        OP_CSRRW     = 3'd0,
        OP_CSRRS     = 3'd1,
        OP_CSRRC     = 3'd2,
        OP_ECALL     = 3'd3,
        OP_MRET      = 3'd4,
        OP_EXCEPTION = 3'd5
    } csr_op_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RESP = 1'b1
    } ctrl_state_t;

    // machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
    localparam csr_addr_t CSR_MHARTID  = 12'hF14;

    // mstatus fields kept by this hart
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

endpackage

`default_nettype wire
